// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_ws_controller \
  -o tb_ws_controller
./obj_dir/tb_ws_controller | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"

// File: sim/tb_ws_controller.sv
`timescale 1ns/10ps

module tb_ws_controller;

  logic                clk = 1'b0;
  logic                reset;
  logic                start_controller;
  ws_ctrl_pkg::count_t num_nij_to_compute;
  ws_ctrl_pkg::count_t num_kij_to_compute;
  ws_ctrl_pkg::addr_t  weight_start_sram_addr;
  ws_ctrl_pkg::addr_t  activation_start_sram_addr;
  logic                ofifo_valid = 1'b0;
  logic                sfu_active = 1'b0;
  logic                execute;
  logic                load;
  logic                mac_reset;
  logic                l0_rd;
  logic                l0_wr;
  logic                ofifo_rd;
  logic                sfu_start;
  logic                sfu_active_to_mem;
  logic                controller_active;
  ws_ctrl_pkg::addr_t  activation_sram_addr;
  ws_ctrl_pkg::addr_t  psum_sram_addr;

  int          checks = 0;
  int          errors = 0;
  logic        timed_out = 1'b0;
  int unsigned rnd = 49;
  int          sfu_left = 0;
  // Scoreboard state
  int          passes = 0;
  int          cur_pass = 0;
  int          wr_idx = 0;
  int          load_cnt = 0;
  int          exec_cnt = 0;
  int          total_loads = 0;
  int          total_execs = 0;
  int          rd_k = 0;
  int          mac_step = -1;
  int          sfu_pulses = 0;
  int          idle_cnt = 0;
  logic        sfu_wait = 1'b0;
  logic        active_q = 1'b0;
  logic        exec_q = 1'b0;
  logic        rd_q = 1'b0;

  ws_controller u_ws_controller (.*);

  always #5 clk = ~clk;

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_eq(input string name, input int expected, input int actual);
    checks++;
    assert (expected == actual) else begin
      $display("ERR %0t %s expected %0d got %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_active(input logic level, input int limit, input string what);
    int i;
    i = 0;
    while (controller_active != level && i < limit) begin
      @(negedge clk);
      i++;
    end
    if (controller_active != level) begin
      $display("Timeout after %0d cycles waiting for %s", limit, what);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_job(input int n, input int k, input int w_start, input int a_start);
    int err_before;
    err_before = errors;
    num_nij_to_compute <= ws_ctrl_pkg::count_t'(n);
    num_kij_to_compute <= ws_ctrl_pkg::count_t'(k);
    weight_start_sram_addr <= ws_ctrl_pkg::addr_t'(w_start);
    activation_start_sram_addr <= ws_ctrl_pkg::addr_t'(a_start);
    start_controller <= 1'b1;
    @(negedge clk);
    start_controller <= 1'b0;
    wait_active(1'b1, 4, "job start");
    if (!timed_out) begin
      wait_active(1'b0, 20000, "job end");
    end
    if (!timed_out) begin
      @(negedge clk);
      check_eq("sfu_start pulses", 1, sfu_pulses);
      check_eq("passes", k, passes);
      check_eq("load cycles in job", k * ws_ctrl_pkg::PE_COLS, total_loads);
      check_eq("execute cycles in job", k * n, total_execs);
    end
    $display("Test job nij=%0d kij=%0d finished with %0d errors", n, k, errors - err_before);
  endtask

  // OFIFO valid from the LCG and SFU busy for 3 to 20 cycles after sfu_start
  always @(negedge clk) begin
    if (!reset) begin
      rnd = lcg_next(rnd);
      ofifo_valid <= ((rnd >> 16) % 10) < 7;
      if (sfu_start) begin
        rnd = lcg_next(rnd);
        sfu_left = 3 + int'((rnd >> 16) % 18);
        sfu_active <= 1'b1;
      end else if (sfu_left > 0) begin
        sfu_left--;
        if (sfu_left == 0)
          sfu_active <= 1'b0;
      end
    end
  end

  // Outputs sampled on the falling edge halfway between DUT updates
  always @(negedge clk) begin
    int n;
    int k;
    n = int'(num_nij_to_compute);
    k = int'(num_kij_to_compute);
    if (reset) begin
      check_eq("strobes in reset", 0, int'({load, execute, mac_reset, l0_rd, l0_wr, ofifo_rd,
                                           sfu_start, sfu_active_to_mem, controller_active}));
      check_eq("addresses in reset", 0, int'(activation_sram_addr | psum_sram_addr));
    end else begin
      if (controller_active && !active_q) begin
        passes = 0;
        wr_idx = 0;
        total_loads = 0;
        total_execs = 0;
        sfu_pulses = 0;
      end
      if (!controller_active) begin
        check_eq("strobes while idle", 0,
                 int'({load, execute, l0_rd, l0_wr, ofifo_rd, sfu_start}));
        check_eq("psum_sram_addr while idle", 0, int'(psum_sram_addr));
      end
      // First weight row opens a new pass
      if (l0_wr && wr_idx == 0) begin
        cur_pass = passes;
        passes++;
        rd_k = 0;
      end
      if (l0_wr && wr_idx < ws_ctrl_pkg::PE_COLS) begin
        check_eq("activation_sram_addr", (int'(weight_start_sram_addr)
                 + cur_pass * ws_ctrl_pkg::PE_COLS + wr_idx) % 2048, int'(activation_sram_addr));
      end else if (l0_wr) begin
        check_eq("activation_sram_addr", (int'(activation_start_sram_addr) + wr_idx
                 - ws_ctrl_pkg::PE_COLS) % 2048, int'(activation_sram_addr));
      end else begin
        check_eq("activation_sram_addr", 0, int'(activation_sram_addr));
      end
      check_eq("mac_reset", int'(l0_wr && wr_idx < 2), int'(mac_reset));
      if (l0_wr)
        wr_idx++;
      check_eq("l0_rd", int'(load || execute), int'(l0_rd));
      if (load) begin
        check_eq("L0 rows written before load", ws_ctrl_pkg::PE_COLS, wr_idx);
        load_cnt++;
        total_loads++;
      end
      if (execute) begin
        check_eq("L0 rows written before execute", ws_ctrl_pkg::PE_COLS + n, wr_idx);
        exec_cnt++;
        total_execs++;
      end
      // Falling execute closes the pass
      if (exec_q && !execute) begin
        check_eq("load cycles in pass", ws_ctrl_pkg::PE_COLS, load_cnt);
        check_eq("execute cycles in pass", n, exec_cnt);
        load_cnt = 0;
        exec_cnt = 0;
        wr_idx = 0;
      end
      // MAC_COMPUTE opens with the first execute and lasts nij + 2*PE_COLS + 3 cycles
      if (execute && !exec_q) begin
        mac_step = 0;
      end else if (mac_step >= 0) begin
        mac_step++;
      end
      if (mac_step > n + 2 * ws_ctrl_pkg::PE_COLS + 2)
        mac_step = -1;
      // Reads follow valid cycles within MAC_COMPUTE but skip its first and last two cycles
      check_eq("ofifo_rd", int'(mac_step >= 1 && mac_step <= n + 2 * ws_ctrl_pkg::PE_COLS
               && ofifo_valid), int'(ofifo_rd));
      // PSUM address trails each read by one cycle
      if (rd_q) begin
        check_eq("psum_sram_addr", (cur_pass * n + rd_k) % 2048, int'(psum_sram_addr));
        rd_k++;
      end
      if (sfu_start) begin
        check_eq("passes at sfu_start", k, passes);
        check_eq("executes before sfu_start", k * n, total_execs);
        sfu_pulses++;
        sfu_wait = 1'b1;
        idle_cnt = 0;
      end else if (sfu_wait && sfu_active) begin
        check_eq("sfu_active_to_mem", 1, int'(sfu_active_to_mem));
        check_eq("controller_active", 1, int'(controller_active));
      end else if (sfu_wait && controller_active) begin
        idle_cnt++;
        check_eq("sfu_active_to_mem", 1, int'(sfu_active_to_mem));
        assert (idle_cnt <= 2) else begin
          $display("controller_active still high %0d cycles after sfu_active fell", idle_cnt);
          errors++;
        end
      end else begin
        sfu_wait = 1'b0;
      end
      if (!sfu_active && !controller_active)
        check_eq("sfu_active_to_mem", 0, int'(sfu_active_to_mem));
      active_q = controller_active;
      exec_q = execute;
      rd_q = ofifo_rd;
    end
  end

  initial begin
    reset = 1'b1;
    start_controller = 1'b0;
    num_nij_to_compute = '0;
    num_kij_to_compute = '0;
    weight_start_sram_addr = '0;
    activation_start_sram_addr = '0;
    repeat (16) @(negedge clk);
    reset <= 1'b0;
    repeat (8) @(negedge clk);
    $display("Test reset finished with %0d errors", errors);
    run_job(12, 3, 100, 600);
    if (!timed_out)
      run_job(5, 2, 1500, 40);
    // Same settings as the first job
    if (!timed_out)
      run_job(12, 3, 100, 600);
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: verilog/ws_addr_gen.sv
`timescale 1ns/10ps

module ws_addr_gen (
  input  logic                clk,
  input  logic                reset,
  ws_phase_if.user            ph,
  input  ws_ctrl_pkg::count_t num_nij_to_compute,
  input  ws_ctrl_pkg::addr_t  weight_start_sram_addr,
  input  ws_ctrl_pkg::addr_t  activation_start_sram_addr,
  input  logic                ofifo_rd,
  output ws_ctrl_pkg::addr_t  activation_sram_addr,
  output ws_ctrl_pkg::addr_t  psum_sram_addr
);

  ws_ctrl_pkg::addr_t weight_off;
  ws_ctrl_pkg::addr_t psum_base;
  ws_ctrl_pkg::addr_t rd_cnt;
  logic               ofifo_rd_q;
  logic               kload_done;
  logic               pass_done;

  assign kload_done = (ph.state == ws_ctrl_pkg::KERNEL_LOAD_TO_L0) && ph.last_step;
  assign pass_done  = (ph.state == ws_ctrl_pkg::MAC_COMPUTE) && ph.last_step;

  always_ff @(posedge clk) begin
    if (reset) begin
      weight_off <= '0;
      psum_base  <= '0;
      rd_cnt     <= '0;
      ofifo_rd_q <= 1'b0;
    end else begin
      ofifo_rd_q <= ofifo_rd;
      // Each pass takes the next PE_COLS weight rows
      if (ph.job_start) begin
        weight_off <= '0;
      end else if (kload_done) begin
        weight_off <= weight_off + ws_ctrl_pkg::addr_t'(ws_ctrl_pkg::PE_COLS);
      end
      // Each pass writes its own block of nij partial sums
      if (ph.job_start) begin
        psum_base <= '0;
      end else if (pass_done) begin
        psum_base <= psum_base + ws_ctrl_pkg::addr_t'(num_nij_to_compute);
      end
      // Lags ofifo_rd by a cycle so the address meets the OFIFO data
      if (ph.job_start || pass_done) begin
        rd_cnt <= '0;
      end else if (ofifo_rd_q) begin
        rd_cnt <= rd_cnt + ws_ctrl_pkg::addr_t'(1);
      end
    end
  end

  always_comb begin
    case (ph.state)
      ws_ctrl_pkg::KERNEL_LOAD_TO_L0:
        activation_sram_addr = weight_start_sram_addr + weight_off
                             + ws_ctrl_pkg::addr_t'(ph.step);
      ws_ctrl_pkg::ACT_LOAD_TO_L0:
        activation_sram_addr = activation_start_sram_addr + ws_ctrl_pkg::addr_t'(ph.step);
      default:
        activation_sram_addr = '0;
    endcase
  end

  assign psum_sram_addr = (ph.state == ws_ctrl_pkg::MAC_COMPUTE) ? psum_base + rd_cnt : '0;

endmodule

// File: verilog/ws_array_ctrl.sv
`timescale 1ns/10ps

module ws_array_ctrl (
  input  logic                clk,
  input  logic                reset,
  ws_phase_if.user            ph,
  input  ws_ctrl_pkg::count_t num_nij_to_compute,
  input  logic                ofifo_valid,
  input  logic                sfu_active,
  output logic                load,
  output logic                execute,
  output logic                mac_reset,
  output logic                l0_rd,
  output logic                l0_wr,
  output logic                ofifo_rd,
  output logic                sfu_start,
  output logic                sfu_active_to_mem
);

  // Step value in the cycle the registered strobes appear
  ws_ctrl_pkg::step_t nstep;
  ws_ctrl_pkg::step_t rd_stop;
  logic               in_kl0;
  logic               in_kmac;
  logic               in_mac;
  logic               load_d;
  logic               execute_d;
  logic               ofifo_rd_d;

  assign nstep = ph.last_step ? '0 : ph.step + ws_ctrl_pkg::step_t'(1);

  // First MAC_COMPUTE step with reads held off
  assign rd_stop = ws_ctrl_pkg::step_t'(num_nij_to_compute)
                 + ws_ctrl_pkg::step_t'(ws_ctrl_pkg::MAC_TAIL_LEN - ws_ctrl_pkg::OFIFO_RD_GUARD);

  assign in_kl0  = (ph.next_state == ws_ctrl_pkg::KERNEL_LOAD_TO_L0);
  assign in_kmac = (ph.next_state == ws_ctrl_pkg::KERNEL_LOAD_TO_MAC);
  assign in_mac  = (ph.next_state == ws_ctrl_pkg::MAC_COMPUTE);

  assign load_d    = in_kmac && (nstep < ws_ctrl_pkg::step_t'(ws_ctrl_pkg::LOAD_LEN));
  assign execute_d = in_mac && (nstep < ws_ctrl_pkg::step_t'(num_nij_to_compute));

  // Read only when the OFIFO showed data during the cycle before, inside MAC_COMPUTE
  assign ofifo_rd_d = in_mac && (ph.state == ws_ctrl_pkg::MAC_COMPUTE)
                    && ofifo_valid && (nstep < rd_stop);

  always_ff @(posedge clk) begin
    if (reset) begin
      load      <= 1'b0;
      execute   <= 1'b0;
      mac_reset <= 1'b0;
      l0_rd     <= 1'b0;
      l0_wr     <= 1'b0;
      ofifo_rd  <= 1'b0;
      sfu_start <= 1'b0;
    end else begin
      load      <= load_d;
      execute   <= execute_d;
      l0_rd     <= load_d || execute_d;
      // Clear the accumulators at the start of every pass
      mac_reset <= in_kl0 && (nstep < ws_ctrl_pkg::step_t'(ws_ctrl_pkg::MAC_RESET_LEN));
      l0_wr     <= in_kl0 || (ph.next_state == ws_ctrl_pkg::ACT_LOAD_TO_L0);
      ofifo_rd  <= ofifo_rd_d;
      sfu_start <= (ph.next_state == ws_ctrl_pkg::SFU_START);
    end
  end

  // Memory side stays with the SFU until it finishes
  assign sfu_active_to_mem = sfu_active || (ph.state == ws_ctrl_pkg::SFU_PROCESS);

endmodule

// File: verilog/ws_controller.sv
`timescale 1ns/10ps

module ws_controller (
  input  logic                clk,
  input  logic                reset,
  input  logic                start_controller,
  // Job configuration, held for the whole job
  input  ws_ctrl_pkg::count_t num_nij_to_compute,
  input  ws_ctrl_pkg::count_t num_kij_to_compute,
  input  ws_ctrl_pkg::addr_t  weight_start_sram_addr,
  input  ws_ctrl_pkg::addr_t  activation_start_sram_addr,
  // MAC array
  output logic                execute,
  output logic                load,
  output logic                mac_reset,
  // L0
  output logic                l0_rd,
  output logic                l0_wr,
  // OFIFO
  input  logic                ofifo_valid,
  output logic                ofifo_rd,
  // SFU
  output logic                sfu_start,
  input  logic                sfu_active,
  output logic                sfu_active_to_mem,
  output logic                controller_active,
  // SRAM addresses
  output ws_ctrl_pkg::addr_t  activation_sram_addr,
  output ws_ctrl_pkg::addr_t  psum_sram_addr
);

  ws_phase_if ph ();

  ws_sequencer u_ws_sequencer (
    .clk                (clk),
    .reset              (reset),
    .start_controller   (start_controller),
    .num_nij_to_compute (num_nij_to_compute),
    .num_kij_to_compute (num_kij_to_compute),
    .sfu_active         (sfu_active),
    .ph                 (ph.seq),
    .controller_active  (controller_active)
  );

  ws_addr_gen u_ws_addr_gen (
    .clk                        (clk),
    .reset                      (reset),
    .ph                         (ph.user),
    .num_nij_to_compute         (num_nij_to_compute),
    .weight_start_sram_addr     (weight_start_sram_addr),
    .activation_start_sram_addr (activation_start_sram_addr),
    .ofifo_rd                   (ofifo_rd),
    .activation_sram_addr       (activation_sram_addr),
    .psum_sram_addr             (psum_sram_addr)
  );

  ws_array_ctrl u_ws_array_ctrl (
    .clk                (clk),
    .reset              (reset),
    .ph                 (ph.user),
    .num_nij_to_compute (num_nij_to_compute),
    .ofifo_valid        (ofifo_valid),
    .sfu_active         (sfu_active),
    .load               (load),
    .execute            (execute),
    .mac_reset          (mac_reset),
    .l0_rd              (l0_rd),
    .l0_wr              (l0_wr),
    .ofifo_rd           (ofifo_rd),
    .sfu_start          (sfu_start),
    .sfu_active_to_mem  (sfu_active_to_mem)
  );

endmodule

// File: verilog/ws_ctrl_pkg.sv
package ws_ctrl_pkg;

  // Array geometry, fixed by the MAC array
  localparam int PE_COLS = 8;

  // Bus widths
  localparam int ADDR_W  = 11;
  localparam int COUNT_W = 8;
  localparam int STEP_W  = 11;

  // Fixed phase lengths in cycles
  localparam int KLOAD_L0_LEN  = PE_COLS;
  localparam int KLOAD_MAC_LEN = 2 * PE_COLS;
  // MAC_COMPUTE runs nij cycles plus this tail for the array to fill and drain
  localparam int MAC_TAIL_LEN  = 2 * PE_COLS + 3;

  // Strobe windows inside a phase
  localparam int MAC_RESET_LEN  = 2;
  localparam int LOAD_LEN       = PE_COLS;
  // No OFIFO reads in the last cycles of MAC_COMPUTE
  localparam int OFIFO_RD_GUARD = 2;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [COUNT_W-1:0] count_t;
  // Wide enough for nij + 2*PE_COLS + 2
  typedef logic [STEP_W-1:0]  step_t;

  typedef enum logic [2:0] {
    IDLE               = 3'd0,
    KERNEL_LOAD_TO_L0  = 3'd1,
    KERNEL_LOAD_TO_MAC = 3'd2,
    ACT_LOAD_TO_L0     = 3'd3,
    MAC_COMPUTE        = 3'd4,
    SFU_START          = 3'd5,
    SFU_PROCESS        = 3'd6
  } ctrl_state_e;

endpackage

// File: verilog/ws_phase_if.sv
`timescale 1ns/10ps

// Phase information published by the sequencer
interface ws_phase_if;

  ws_ctrl_pkg::ctrl_state_e state;
  ws_ctrl_pkg::ctrl_state_e next_state;
  // Cycle count within the current phase, from 0
  ws_ctrl_pkg::step_t       step;
  // Final cycle of the current phase
  logic                     last_step;
  // IDLE cycle that accepts start_controller
  logic                     job_start;

  modport seq (
    output state,
    output next_state,
    output step,
    output last_step,
    output job_start
  );

  modport user (
    input state,
    input next_state,
    input step,
    input last_step,
    input job_start
  );

endinterface

// File: verilog/ws_sequencer.sv
`timescale 1ns/10ps

module ws_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                start_controller,
  input  ws_ctrl_pkg::count_t num_nij_to_compute,
  input  ws_ctrl_pkg::count_t num_kij_to_compute,
  input  logic                sfu_active,
  ws_phase_if.seq             ph,
  output logic                controller_active
);

  ws_ctrl_pkg::ctrl_state_e state;
  ws_ctrl_pkg::ctrl_state_e next_state;
  ws_ctrl_pkg::step_t       step;
  ws_ctrl_pkg::count_t      pass_idx;
  logic                     last_step;
  logic                     job_start;
  logic                     last_pass;
  ws_ctrl_pkg::step_t       act_last;
  ws_ctrl_pkg::step_t       mac_last;

  assign job_start = (state == ws_ctrl_pkg::IDLE) && start_controller;
  assign last_pass = (pass_idx == num_kij_to_compute - ws_ctrl_pkg::count_t'(1));

  // Last step index of the nij-dependent phases
  assign act_last = ws_ctrl_pkg::step_t'(num_nij_to_compute) - ws_ctrl_pkg::step_t'(1);
  assign mac_last = ws_ctrl_pkg::step_t'(num_nij_to_compute)
                  + ws_ctrl_pkg::step_t'(ws_ctrl_pkg::MAC_TAIL_LEN - 1);

  always_comb begin
    case (state)
      ws_ctrl_pkg::IDLE:
        last_step = job_start;
      ws_ctrl_pkg::KERNEL_LOAD_TO_L0:
        last_step = (step == ws_ctrl_pkg::step_t'(ws_ctrl_pkg::KLOAD_L0_LEN - 1));
      ws_ctrl_pkg::KERNEL_LOAD_TO_MAC:
        last_step = (step == ws_ctrl_pkg::step_t'(ws_ctrl_pkg::KLOAD_MAC_LEN - 1));
      ws_ctrl_pkg::ACT_LOAD_TO_L0:
        last_step = (step == act_last);
      ws_ctrl_pkg::MAC_COMPUTE:
        last_step = (step == mac_last);
      ws_ctrl_pkg::SFU_START:
        last_step = 1'b1;
      // Leaves once the SFU reports idle
      ws_ctrl_pkg::SFU_PROCESS:
        last_step = !sfu_active;
      default:
        last_step = 1'b1;
    endcase
  end

  always_comb begin
    next_state = state;
    case (state)
      ws_ctrl_pkg::IDLE: begin
        if (job_start) begin
          next_state = ws_ctrl_pkg::KERNEL_LOAD_TO_L0;
        end
      end
      ws_ctrl_pkg::KERNEL_LOAD_TO_L0: begin
        if (last_step) begin
          next_state = ws_ctrl_pkg::KERNEL_LOAD_TO_MAC;
        end
      end
      ws_ctrl_pkg::KERNEL_LOAD_TO_MAC: begin
        if (last_step) begin
          next_state = ws_ctrl_pkg::ACT_LOAD_TO_L0;
        end
      end
      ws_ctrl_pkg::ACT_LOAD_TO_L0: begin
        if (last_step) begin
          next_state = ws_ctrl_pkg::MAC_COMPUTE;
        end
      end
      ws_ctrl_pkg::MAC_COMPUTE: begin
        if (last_step) begin
          next_state = last_pass ? ws_ctrl_pkg::SFU_START : ws_ctrl_pkg::KERNEL_LOAD_TO_L0;
        end
      end
      ws_ctrl_pkg::SFU_START: begin
        next_state = ws_ctrl_pkg::SFU_PROCESS;
      end
      ws_ctrl_pkg::SFU_PROCESS: begin
        if (last_step) begin
          next_state = ws_ctrl_pkg::IDLE;
        end
      end
      default: begin
        next_state = ws_ctrl_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state             <= ws_ctrl_pkg::IDLE;
      step              <= '0;
      pass_idx          <= '0;
      controller_active <= 1'b0;
    end else begin
      state             <= next_state;
      controller_active <= (next_state != ws_ctrl_pkg::IDLE);
      // Step restarts at every phase change, idle holds it at 0
      if (last_step || (state == ws_ctrl_pkg::IDLE)) begin
        step <= '0;
      end else begin
        step <= step + ws_ctrl_pkg::step_t'(1);
      end
      if (job_start) begin
        pass_idx <= '0;
      end else if ((state == ws_ctrl_pkg::MAC_COMPUTE) && last_step) begin
        pass_idx <= pass_idx + ws_ctrl_pkg::count_t'(1);
      end
    end
  end

  assign ph.state      = state;
  assign ph.next_state = next_state;
  assign ph.step       = step;
  assign ph.last_step  = last_step;
  assign ph.job_start  = job_start;

endmodule

// File: vlog.f
verilog/ws_ctrl_pkg.sv
verilog/ws_phase_if.sv
verilog/ws_sequencer.sv
verilog/ws_addr_gen.sv
verilog/ws_array_ctrl.sv
verilog/ws_controller.sv
sim/tb_ws_controller.sv
